/* hdl/fetch_pkg.sv */
package fetch_pkg;

    typedef logic [31:0] addr_t;

    // physical address split for the icache ports, tag highest
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;

    localparam int PFN_W = 20; // page frame number from the itlb lookup

    // branch bus from decode
    typedef struct packed {
        logic  br_stall;  // branch operands not ready yet
        logic  br_taken;
        addr_t br_target;
    } br_bus_t;

    // boot rom entry in kseg1
    localparam addr_t RESET_VECTOR_DEFAULT = 32'hbfc0_0000;
    // general exception entry while bev is set
    localparam addr_t EXC_VECTOR_DEFAULT   = 32'hbfc0_0380;

endpackage

/* hdl/ps_fs_if.sv */
`timescale 1ns/1ps

interface ps_fs_if;
    fetch_pkg::addr_t pc;         // address of the request accepted this cycle
    logic             req_fire;   // inst_valid and inst_addr_ok together
    logic             fs_allowin;
    fetch_pkg::addr_t fs_pc;      // pc of the word held in IF
    logic             cancel;     // flush or eret this cycle

    // pre-IF side drives the request and the kill
    modport pre (
        output pc,
        output req_fire,
        output cancel,
        input  fs_allowin,
        input  fs_pc
    );

    modport fs (
        input  pc,
        input  req_fire,
        input  cancel,
        output fs_allowin,
        output fs_pc
    );
endinterface

/* hdl/itlb_translate.sv */
`timescale 1ns/1ps

module itlb_translate (
    input  fetch_pkg::addr_t            vaddr,
    input  logic                        itlb_found,
    input  logic [fetch_pkg::PFN_W-1:0] itlb_pfn,
    input  logic                        itlb_v,
    output fetch_pkg::addr_t            paddr,
    output logic                        refill
);
    localparam int PAGE_OFS_W = 32 - fetch_pkg::PFN_W; // 4k pages

    logic             unmapped;
    fetch_pkg::addr_t seg_paddr;
    fetch_pkg::addr_t map_paddr;

    // kseg0 8000_0000..9fff_ffff and kseg1 a000_0000..bfff_ffff
    assign unmapped = (vaddr[31:30] == 2'b10);

    // both segments alias the low 512M of physical space
    assign seg_paddr = {3'b000, vaddr[28:0]};

    // kuseg and kseg2/3 go through the lookup result
    assign map_paddr = {itlb_pfn, vaddr[PAGE_OFS_W-1:0]};

    always_comb begin
        if (unmapped) begin
            paddr  = seg_paddr;
            refill = 1'b0;           // never faults
        end else begin
            paddr  = map_paddr;
            // missing entry or v bit clear, both refill from the fetch side
            refill = ~itlb_found | ~itlb_v;
        end
    end

endmodule

/* hdl/pre_if_stage.sv */
`timescale 1ns/1ps

module pre_if_stage #(
    parameter fetch_pkg::addr_t reset_vector = fetch_pkg::RESET_VECTOR_DEFAULT,
    parameter fetch_pkg::addr_t exc_vector   = fetch_pkg::EXC_VECTOR_DEFAULT
) (
    input  logic                           clk,
    input  logic                           reset,
    input  fetch_pkg::br_bus_t             br_bus,
    input  logic                           flush,
    input  logic                           eret,
    input  fetch_pkg::addr_t               epc,
    input  logic                           mfc0_stall,
    input  logic                           itlb_found,
    input  logic [fetch_pkg::PFN_W-1:0]    itlb_pfn,
    input  logic                           itlb_v,
    input  logic                           inst_addr_ok,
    input  logic                           inst_data_ok,
    output logic                           inst_valid,
    output logic [fetch_pkg::TAG_W-1:0]    inst_tag,
    output logic [fetch_pkg::INDEX_W-1:0]  inst_index,
    output logic [fetch_pkg::OFFSET_W-1:0] inst_offset,
    output logic                           refill_req,
    ps_fs_if.pre                           ps
);
    fetch_pkg::addr_t next_pc;       // address for the next sequential request
    fetch_pkg::addr_t fetch_pc;
    fetch_pkg::addr_t fetch_paddr;
    logic             outstanding;   // one request waiting for data_ok
    logic             flush_pending;
    logic             fetch_en;
    logic             redirect;
    logic             br_ok;

    assign redirect = eret | flush | flush_pending;

    // branch only counts when decode has resolved it and nothing redirects
    assign br_ok = br_bus.br_taken & ~br_bus.br_stall & ~mfc0_stall & ~redirect;

    always_comb begin
        if (eret)
            fetch_pc = epc;
        else if (flush | flush_pending)
            fetch_pc = exc_vector;
        else
            fetch_pc = next_pc;
    end

    always_ff @(posedge clk) begin
        if (reset)
            next_pc <= reset_vector;
        else if (ps.req_fire)
            next_pc <= br_ok ? br_bus.br_target : fetch_pc + 32'd4;
        else if (eret)
            next_pc <= epc;     // hold the return address until it goes out
    end

    // keeps the vector selected while the stale request drains
    always_ff @(posedge clk) begin
        if (reset)
            flush_pending <= 1'b0;
        else if (eret | ps.req_fire)
            flush_pending <= 1'b0;
        else if (flush)
            flush_pending <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset)
            outstanding <= 1'b0;
        else if (ps.req_fire)
            outstanding <= 1'b1;
        else if (inst_data_ok)
            outstanding <= 1'b0;
    end

    // first request in the cycle after the first edge with reset low
    always_ff @(posedge clk) begin
        if (reset)
            fetch_en <= 1'b0;
        else
            fetch_en <= 1'b1;
    end

    itlb_translate i_itlb_translate (
        .vaddr      (fetch_pc),
        .itlb_found (itlb_found),
        .itlb_pfn   (itlb_pfn),
        .itlb_v     (itlb_v),
        .paddr      (fetch_paddr),
        .refill     (refill_req)
    );

    assign inst_valid = fetch_en & ~outstanding & (ps.fs_allowin | redirect);

    assign {inst_tag, inst_index, inst_offset} = fetch_paddr;

    assign ps.pc       = fetch_pc;
    assign ps.req_fire = inst_valid & inst_addr_ok;
    assign ps.cancel   = flush | eret;

    // word aligned after translation too
    a_req_aligned: assert property (
        @(posedge clk) disable iff (reset)
        inst_valid |-> inst_offset[1:0] == 2'b00
    );

    // no second accept before the first one has returned its data
    a_one_outstanding: assert property (
        @(posedge clk) disable iff (reset)
        ps.req_fire |=> (!ps.req_fire until_with inst_data_ok)
    );

endmodule

/* hdl/if_stage.sv */
`timescale 1ns/1ps

module if_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             inst_data_ok,
    input  logic [31:0]      inst_rdata,
    input  logic             refill_req,
    input  logic             ds_allowin,
    ps_fs_if.fs              fs,
    output logic             fs_to_ds_valid,
    output fetch_pkg::addr_t fs_pc_out,
    output logic [31:0]      fs_inst,
    output logic             fs_tlb_refill
);
    fetch_pkg::addr_t req_pc;      // pc of the request in flight
    logic             req_refill;
    logic             inflight;
    logic             drop;        // in-flight request was cancelled earlier
    logic             stale;
    logic             load;
    logic             fs_valid;
    fetch_pkg::addr_t pc_q;
    logic [31:0]      inst_q;
    logic             refill_q;

    // a cancel in the data_ok cycle also kills that response
    assign stale = drop | (fs.cancel & inflight);
    assign load  = inst_data_ok & inflight & ~stale;

    always_ff @(posedge clk) begin
        if (reset)
            inflight <= 1'b0;
        else if (fs.req_fire)
            inflight <= 1'b1;
        else if (inst_data_ok)
            inflight <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset)
            drop <= 1'b0;
        else if (inst_data_ok)
            drop <= 1'b0;            // stale word has come back
        else if (fs.cancel & inflight)
            drop <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (fs.req_fire) begin
            req_pc     <= fs.pc;
            req_refill <= refill_req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            fs_valid <= 1'b0;
        else if (fs.cancel)
            fs_valid <= 1'b0;
        else if (load)
            fs_valid <= 1'b1;
        else if (ds_allowin)
            fs_valid <= 1'b0;        // taken by decode
    end

    always_ff @(posedge clk) begin
        if (load) begin
            pc_q     <= req_pc;
            inst_q   <= inst_rdata;
            refill_q <= req_refill;
        end
    end

    // room for the next response once the current word leaves
    assign fs.fs_allowin = ~fs_valid | ds_allowin;
    assign fs.fs_pc      = pc_q;

    assign fs_to_ds_valid = fs_valid;
    assign fs_pc_out      = fs.fs_pc;
    assign fs_inst        = inst_q;
    assign fs_tlb_refill  = refill_q;

    // decode stall must freeze the word, so pre-IF may not refill IF meanwhile
    a_hold_under_stall: assert property (
        @(posedge clk) disable iff (reset)
        fs_to_ds_valid && !ds_allowin && !fs.cancel |=>
            fs_to_ds_valid && $stable(fs_pc_out) && $stable(fs_inst)
            && $stable(fs_tlb_refill)
    );

endmodule

/* hdl/fetch_front.sv */
`timescale 1ns/1ps

module fetch_front #(
    parameter fetch_pkg::addr_t reset_vector = fetch_pkg::RESET_VECTOR_DEFAULT,
    parameter fetch_pkg::addr_t exc_vector   = fetch_pkg::EXC_VECTOR_DEFAULT
) (
    input  logic                           clk,
    input  logic                           reset,
    input  fetch_pkg::br_bus_t             br_bus,
    input  logic                           flush,
    input  logic                           eret,
    input  fetch_pkg::addr_t               epc,
    input  logic                           mfc0_stall,
    // itlb lookup result for the current fetch address
    input  logic                           itlb_found,
    input  logic [fetch_pkg::PFN_W-1:0]    itlb_pfn,
    input  logic                           itlb_v,
    // icache request side
    output logic                           inst_valid,
    output logic [fetch_pkg::TAG_W-1:0]    inst_tag,
    output logic [fetch_pkg::INDEX_W-1:0]  inst_index,
    output logic [fetch_pkg::OFFSET_W-1:0] inst_offset,
    input  logic                           inst_addr_ok,
    input  logic                           inst_data_ok,
    input  logic [31:0]                    inst_rdata,
    // to decode
    output logic                           fs_to_ds_valid,
    output fetch_pkg::addr_t               fs_pc_out,
    output logic [31:0]                    fs_inst,
    output logic                           fs_tlb_refill,
    input  logic                           ds_allowin
);
    logic refill_req;   // refill flag of the address being requested

    ps_fs_if ps_fs ();

    pre_if_stage #(
        .reset_vector (reset_vector),
        .exc_vector   (exc_vector)
    ) i_pre_if_stage (
        .clk          (clk),
        .reset        (reset),
        .br_bus       (br_bus),
        .flush        (flush),
        .eret         (eret),
        .epc          (epc),
        .mfc0_stall   (mfc0_stall),
        .itlb_found   (itlb_found),
        .itlb_pfn     (itlb_pfn),
        .itlb_v       (itlb_v),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_valid   (inst_valid),
        .inst_tag     (inst_tag),
        .inst_index   (inst_index),
        .inst_offset  (inst_offset),
        .refill_req   (refill_req),
        .ps           (ps_fs.pre)
    );

    if_stage i_if_stage (
        .clk            (clk),
        .reset          (reset),
        .inst_data_ok   (inst_data_ok),
        .inst_rdata     (inst_rdata),
        .refill_req     (refill_req),
        .ds_allowin     (ds_allowin),
        .fs             (ps_fs.fs),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc_out      (fs_pc_out),
        .fs_inst        (fs_inst),
        .fs_tlb_refill  (fs_tlb_refill)
    );

endmodule

/* sim/icache_stub.sv */
`timescale 1ns/1ps

// instruction cache model, one request in flight at a time
module icache_stub (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [31:0]                    rnd,      // new random word every cycle
    input  logic                           inst_valid,
    input  logic [fetch_pkg::TAG_W-1:0]    inst_tag,
    input  logic [fetch_pkg::INDEX_W-1:0]  inst_index,
    input  logic [fetch_pkg::OFFSET_W-1:0] inst_offset,
    output logic                           inst_addr_ok,
    output logic                           inst_data_ok,
    output logic [31:0]                    inst_rdata
);
    localparam logic [31:0] DATA_KEY = 32'ha40a_5a5a;

    logic        busy;              // accepted, data not yet returned
    logic [1:0]  delay;             // cycles left before data_ok
    logic [31:0] paddr;
    logic        addr_ok_q = 1'b0;
    logic        data_ok_q = 1'b0;
    logic [31:0] rdata_q   = 32'h0;

    always @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            delay <= 2'd0;
        end else if (inst_valid && inst_addr_ok) begin
            busy  <= 1'b1;
            delay <= 2'(rnd[15:0] % 3);   // data one to three cycles later
            paddr <= {inst_tag, inst_index, inst_offset};
        end else if (inst_data_ok) begin
            busy <= 1'b0;
        end else if (busy && delay != 2'd0) begin
            delay <= delay - 2'd1;
        end
    end

    // outputs only move on the falling edge
    always @(negedge clk) begin
        addr_ok_q <= !reset && !busy && rnd[1:0] != 2'b00;   // about three cycles in four
        data_ok_q <= !reset && busy && delay == 2'd0;
        rdata_q   <= paddr ^ DATA_KEY;
    end

    assign inst_addr_ok = addr_ok_q;
    assign inst_data_ok = data_ok_q;
    assign inst_rdata   = rdata_q;

endmodule

/* sim/fetch_front_tb.sv */
`timescale 1ns/1ps

module fetch_front_tb;
    localparam fetch_pkg::addr_t RESET_VEC = fetch_pkg::RESET_VECTOR_DEFAULT;
    localparam fetch_pkg::addr_t EXC_VEC   = fetch_pkg::EXC_VECTOR_DEFAULT;
    localparam logic [31:0]      DATA_KEY  = 32'ha40a_5a5a;
    // about 75 words at under ten cycles each, heavy stall included, with wide margin
    localparam int CYCLE_LIMIT = 4000;

    logic                           clk = 1'b0;
    logic                           reset = 1'b1;
    fetch_pkg::br_bus_t             br_bus = '0;
    logic                           flush = 1'b0;
    logic                           eret = 1'b0;
    fetch_pkg::addr_t               epc = '0;
    logic                           mfc0_stall = 1'b0;
    logic                           itlb_found = 1'b1;
    logic [fetch_pkg::PFN_W-1:0]    itlb_pfn = 20'h1a2b3;
    logic                           itlb_v = 1'b1;
    logic                           ds_allowin = 1'b0;
    logic                           inst_valid;
    logic [fetch_pkg::TAG_W-1:0]    inst_tag;
    logic [fetch_pkg::INDEX_W-1:0]  inst_index;
    logic [fetch_pkg::OFFSET_W-1:0] inst_offset;
    logic                           inst_addr_ok;
    logic                           inst_data_ok;
    logic [31:0]                    inst_rdata;
    logic                           fs_to_ds_valid;
    fetch_pkg::addr_t               fs_pc_out;
    logic [31:0]                    fs_inst;
    logic                           fs_tlb_refill;

    logic [31:0]      rnd = 32'h0db0_f1e0;
    logic             heavy_stall = 1'b0;
    fetch_pkg::addr_t br_tgt = '0;

    // reference model of the fetch address and of the word owed to decode
    fetch_pkg::addr_t seq_pc;
    logic             vec_pending;     // flush seen, vector not requested yet
    fetch_pkg::addr_t want_pc;
    fetch_pkg::addr_t req_addr;
    logic             accept;
    logic             cancel;
    logic             br_ok;
    logic             transfer;
    logic             fly_v;
    logic             fly_dead;        // cancelled while in flight
    fetch_pkg::addr_t fly_pc;
    logic [31:0]      fly_paddr;
    logic             fly_refill;
    logic             held_v;
    fetch_pkg::addr_t held_pc;
    logic [31:0]      held_inst;
    logic             held_refill;

    int errors = 0;
    int cycles = 0;
    int n_accepts = 0;
    int n_words = 0;
    int n_exc = 0;
    int n_epc = 0;
    int n_branch = 0;
    int n_mapped = 0;
    int n_refill = 0;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // kseg0/kseg1 lose the segment bits, everything else takes the page frame
    function automatic logic [31:0] phys_addr(input logic [31:0] va,
                                              input logic [fetch_pkg::PFN_W-1:0] pfn);
        return (va[31:30] == 2'b10) ? (va & 32'h1fff_ffff) : {pfn, va[11:0]};
    endfunction

    fetch_front #(
        .reset_vector (RESET_VEC),
        .exc_vector   (EXC_VEC)
    ) i_fetch_front (
        .clk            (clk),
        .reset          (reset),
        .br_bus         (br_bus),
        .flush          (flush),
        .eret           (eret),
        .epc            (epc),
        .mfc0_stall     (mfc0_stall),
        .itlb_found     (itlb_found),
        .itlb_pfn       (itlb_pfn),
        .itlb_v         (itlb_v),
        .inst_valid     (inst_valid),
        .inst_tag       (inst_tag),
        .inst_index     (inst_index),
        .inst_offset    (inst_offset),
        .inst_addr_ok   (inst_addr_ok),
        .inst_data_ok   (inst_data_ok),
        .inst_rdata     (inst_rdata),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc_out      (fs_pc_out),
        .fs_inst        (fs_inst),
        .fs_tlb_refill  (fs_tlb_refill),
        .ds_allowin     (ds_allowin)
    );

    icache_stub i_icache_stub (
        .clk          (clk),
        .reset        (reset),
        .rnd          (rnd),
        .inst_valid   (inst_valid),
        .inst_tag     (inst_tag),
        .inst_index   (inst_index),
        .inst_offset  (inst_offset),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata)
    );

    always #20 clk = ~clk;

    // decode side, takes a word most cycles unless heavily stalled
    always @(negedge clk) begin
        rnd <= next_rand(rnd);
        if (heavy_stall)
            ds_allowin <= rnd[7:5] == 3'b000;
        else
            ds_allowin <= rnd[7:6] != 2'b00;
    end

    assign cancel   = flush | eret;
    assign accept   = inst_valid & inst_addr_ok;
    assign want_pc  = eret ? epc : (flush | vec_pending) ? EXC_VEC : seq_pc;
    assign br_ok    = br_bus.br_taken & ~br_bus.br_stall & ~mfc0_stall & ~cancel & ~vec_pending;
    assign req_addr = {inst_tag, inst_index, inst_offset};
    assign transfer = fs_to_ds_valid & ds_allowin & ~cancel;

    always @(posedge clk) begin
        if (reset) begin
            seq_pc      <= RESET_VEC;
            vec_pending <= 1'b0;
            fly_v       <= 1'b0;
            fly_dead    <= 1'b0;
            held_v      <= 1'b0;
        end else begin
            if (accept) begin
                seq_pc    <= br_ok ? br_bus.br_target : want_pc + 32'd4;
                n_accepts <= n_accepts + 1;
            end else if (eret) begin
                seq_pc <= epc;                 // return address waits for its request
            end
            if (eret || accept)
                vec_pending <= 1'b0;
            else if (flush)
                vec_pending <= 1'b1;
            if (accept) begin
                fly_v      <= 1'b1;
                fly_dead   <= 1'b0;
                fly_pc     <= want_pc;
                fly_paddr  <= phys_addr(want_pc, itlb_pfn);
                fly_refill <= (want_pc[31:30] != 2'b10) && !(itlb_found && itlb_v);
            end else if (inst_data_ok) begin
                fly_v <= 1'b0;
            end else if (cancel && fly_v) begin
                fly_dead <= 1'b1;
            end
            if (cancel) begin
                held_v <= 1'b0;
            end else if (inst_data_ok && fly_v && !fly_dead) begin
                held_v      <= 1'b1;
                held_pc     <= fly_pc;
                held_inst   <= fly_paddr ^ DATA_KEY;
                held_refill <= fly_refill;
            end else if (ds_allowin) begin
                held_v <= 1'b0;
            end
        end
    end

    // what reached decode, for the closing coverage check
    always @(posedge clk) begin
        if (!reset && transfer) begin
            n_words <= n_words + 1;
            if (fs_pc_out == EXC_VEC)
                n_exc <= n_exc + 1;
            if (fs_pc_out == epc)
                n_epc <= n_epc + 1;
            if (fs_pc_out == br_tgt)
                n_branch <= n_branch + 1;
            if (fs_tlb_refill)
                n_refill <= n_refill + 1;
            else if (fs_pc_out[31:30] != 2'b10)
                n_mapped <= n_mapped + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            errors++;
            $display("run stopped after %0d cycles, the stimulus did not complete", cycles);
            finish_run();
        end
    end

    a_req_addr: assert property (@(posedge clk) disable iff (reset)
        inst_valid |-> req_addr == phys_addr(want_pc, itlb_pfn))
        else begin
            errors++;
            $display("Error: {inst_tag,inst_index,inst_offset} = %h, expected %h at %0t",
                     $sampled(req_addr), phys_addr($sampled(want_pc), $sampled(itlb_pfn)), $time);
        end

    a_full_no_req: assert property (@(posedge clk) disable iff (reset)
        fs_to_ds_valid && !ds_allowin && !cancel && !vec_pending |-> !inst_valid)
        else begin
            errors++;
            $display("Error: inst_valid = %h, expected 0 with IF full at %0t",
                     $sampled(inst_valid), $time);
        end

    a_fs_valid: assert property (@(posedge clk) disable iff (reset)
        fs_to_ds_valid == held_v)
        else begin
            errors++;
            $display("Error: fs_to_ds_valid = %h, expected %h at %0t",
                     $sampled(fs_to_ds_valid), $sampled(held_v), $time);
        end

    a_fs_pc: assert property (@(posedge clk) disable iff (reset)
        fs_to_ds_valid |-> fs_pc_out == held_pc)
        else begin
            errors++;
            $display("Error: fs_pc_out = %h, expected %h at %0t",
                     $sampled(fs_pc_out), $sampled(held_pc), $time);
        end

    a_fs_inst: assert property (@(posedge clk) disable iff (reset)
        fs_to_ds_valid |-> fs_inst == held_inst)
        else begin
            errors++;
            $display("Error: fs_inst = %h, expected %h at %0t",
                     $sampled(fs_inst), $sampled(held_inst), $time);
        end

    a_fs_refill: assert property (@(posedge clk) disable iff (reset)
        fs_to_ds_valid |-> fs_tlb_refill == held_refill)
        else begin
            errors++;
            $display("Error: fs_tlb_refill = %h, expected %h at %0t",
                     $sampled(fs_tlb_refill), $sampled(held_refill), $time);
        end

    // the very first word comes from the reset vector
    a_first_pc: assert property (@(posedge clk) disable iff (reset)
        fs_to_ds_valid && n_words == 0 |-> fs_pc_out == RESET_VEC)
        else begin
            errors++;
            $display("Error: first fs_pc_out = %h, expected %h",
                     $sampled(fs_pc_out), RESET_VEC);
        end

    task automatic wait_words(input int n);
        int target;
        target = n_words + n;
        while (n_words < target)
            @(negedge clk);
    endtask

    // hold the branch until one request has been accepted with it
    task automatic branch_at(input fetch_pkg::addr_t target, input logic stall);
        int start;
        start = n_accepts;
        if (!stall)
            br_tgt <= target;
        br_bus.br_taken  <= 1'b1;
        br_bus.br_stall  <= stall;
        br_bus.br_target <= target;
        while (n_accepts == start)
            @(negedge clk);
        br_bus <= '0;
    endtask

    task automatic pulse_flush();
        flush <= 1'b1;
        @(negedge clk);
        flush <= 1'b0;
    endtask

    task automatic return_to(input fetch_pkg::addr_t target);
        epc  <= target;
        eret <= 1'b1;
        @(negedge clk);
        eret <= 1'b0;
    endtask

    task automatic expect_seen(input int count, input string what);
        if (count == 0) begin
            errors++;
            $display("no word %s ever reached decode", what);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d, words delivered: %0d, cycles: %0d", errors, n_words, cycles);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    endtask

    initial begin
        repeat (2) @(negedge clk);
        reset <= 1'b0;
        wait_words(16);
        branch_at(32'hbfc0_1000, 1'b0);
        wait_words(6);
        branch_at(32'hbfc0_2000, 1'b1);   // unresolved, stays sequential
        wait_words(6);
        while (!fly_v)
            @(negedge clk);
        pulse_flush();                    // kills the fetch in flight
        wait_words(6);
        repeat (3) @(negedge clk);
        pulse_flush();
        wait_words(6);
        return_to(32'h0040_0100);         // kuseg, goes through the tlb
        wait_words(8);
        itlb_found <= 1'b0;
        wait_words(5);
        itlb_found <= 1'b1;
        itlb_v     <= 1'b0;
        wait_words(4);
        itlb_v <= 1'b1;
        return_to(32'h8000_0200);
        wait_words(6);
        heavy_stall <= 1'b1;
        wait_words(8);
        heavy_stall <= 1'b0;
        wait_words(4);
        expect_seen(n_branch, "from the branch target");
        expect_seen(n_exc, "from the exception vector");
        expect_seen(n_epc, "from the return address");
        expect_seen(n_mapped, "from a mapped page");
        expect_seen(n_refill, "with the refill flag");
        finish_run();
    end

endmodule

/* vlog.f */
hdl/fetch_pkg.sv
hdl/ps_fs_if.sv
hdl/itlb_translate.sv
hdl/pre_if_stage.sv
hdl/if_stage.sv
hdl/fetch_front.sv
sim/icache_stub.sv
sim/fetch_front_tb.sv
